/* Makefile */
# Verilator build and run of the ADC SPI control subsystem testbench

VERILATOR ?= verilator
TOP       ?= adc_spi_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "TEST FAILED"; exit 1; \
	else \
		echo "TEST OK"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
source/adc_pkg.sv
source/adc_cfg_rom.sv
source/spi_master.sv
source/adc_ctrl.sv
source/adc_spi_top.sv
verification/adc_spi_model.sv
verification/adc_spi_tb.sv

/* source/adc_cfg_rom.sv */
/* ADC register configuration table
   Maps the frame index to a register write or to the conversion read command */
`timescale 1ns/1ps

module adc_cfg_rom import adc_pkg::*; #(
    parameter int unsigned cfg_count = 16
) (
    input  logic         clk_sys,
    input  logic         rst_sys_n,
    input  frame_index_t frame_index,
    output adc_cmd_t     cmd
);

    // Writes are {1'b0, addr, data}, table repeats past 16 entries
    localparam adc_cmd_t cfg_table [0:15] = '{
        16'h0080,   // Soft reset
        16'h0100,   // Normal power mode
        16'h021f,   // Channel enable mask
        16'h0304,   // Oversampling ratio
        16'h0400,   // PGA gain 1x
        16'h0522,   // Internal reference
        16'h0603,   // Straight binary, 16 bit
        16'h0710,   // Digital filter
        16'h0800,   // Offset trim high
        16'h0900,   // Offset trim low
        16'h0a40,   // Gain trim
        16'h0b0c,   // Conversion clock divider
        16'h0c01,   // Sequencer single channel
        16'h0d00,   // Test pattern off
        16'h0e08,   // Input mux
        16'h0f01    // Enable conversions
    };
    // Read flag set, result register
    localparam adc_cmd_t rd_cmd = 16'h9000;

    always_comb begin
        if (frame_index == frame_index_t'(cfg_count + 1)) begin
            cmd = rd_cmd;
        end else if (frame_index != '0 && frame_index <= frame_index_t'(cfg_count)) begin
            cmd = cfg_table[4'(frame_index - 1'b1)];
        end else begin
            cmd = '0;
        end
    end

    // Controller must stay inside the table
    assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        frame_index <= frame_index_t'(cfg_count + 1))
        else $error("frame index %0d beyond read command entry", frame_index);

endmodule

/* source/adc_ctrl.sv */
/* ADC power-up configuration and read sequencer
   Writes the register table frame by frame with settling gaps, then serves reads */
`timescale 1ns/1ps

module adc_ctrl import adc_pkg::*; #(
    parameter int unsigned cfg_count  = 16,
    parameter int unsigned gap_cycles = 255
) (
    input  logic         clk_sys,
    input  logic         rst_sys_n,
    input  logic         pw_on_en,
    input  logic         rd_en,
    input  adc_cmd_t     cmd,
    input  spi_rsp_t     rsp,
    output frame_index_t frame_index,
    output spi_req_t     req,
    output logic         busy,
    output logic         cfg_done,
    output logic         rd_dval,
    output adc_sample_t  rd_data
);

    localparam int gap_w = (gap_cycles > 0) ? $clog2(gap_cycles + 1) : 1;

    ctrl_state_t      state;
    ctrl_state_t      next_state;
    logic [gap_w-1:0] gap_cnt;
    logic             gap_end;
    // Set while a read frame and its gap are in progress
    logic             rd_op;
    // Set by start, cleared once the frame and its gap are over
    logic             hold_off;

    // Last cycle of the settling gap
    assign gap_end = (state == gap_wait) && (gap_cnt == gap_w'(gap_cycles));

    // Start in the single ready cycle, command word in the upper half
    assign req = '{start: (state == cfg_ready) || (state == rd_ready),
                   word:  {cmd, 16'h0000}};

    // --------------------
    // State machine
    // --------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (pw_on_en) begin
                    next_state = cfg_ready;
                end
            end
            cfg_ready: begin
                next_state = cfg_wait;
            end
            cfg_wait: begin
                // No gap after the last table entry
                if (rsp.done) begin
                    if (frame_index == frame_index_t'(cfg_count)) begin
                        next_state = ready_idle;
                    end else begin
                        next_state = gap_wait;
                    end
                end
            end
            ready_idle: begin
                if (rd_en) begin
                    next_state = rd_ready;
                end
            end
            rd_ready: begin
                next_state = rd_wait;
            end
            rd_wait: begin
                if (rsp.done) begin
                    next_state = gap_wait;
                end
            end
            gap_wait: begin
                if (gap_end) begin
                    next_state = cfg_done ? ready_idle : cfg_ready;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    // --------------------
    // Counters and flags
    // --------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            gap_cnt     <= '0;
            rd_op       <= 1'b0;
            hold_off    <= 1'b0;
            frame_index <= '0;
            cfg_done    <= 1'b0;
            busy        <= 1'b0;
        end else begin
            if (state == gap_wait) begin
                gap_cnt <= gap_cnt + 1'b1;
            end else begin
                gap_cnt <= '0;
            end

            if (state == rd_ready) begin
                rd_op <= 1'b1;
            end else if (state == ready_idle || state == cfg_ready) begin
                rd_op <= 1'b0;
            end

            // Released at the end of the gap, or in ready_idle when no gap follows
            if (req.start) begin
                hold_off <= 1'b1;
            end else if (gap_end || state == ready_idle) begin
                hold_off <= 1'b0;
            end

            // Index moves on entry so the table output is ready with start
            case (next_state)
                idle:       frame_index <= '0;
                cfg_ready:  frame_index <= frame_index + 1'b1;
                ready_idle: frame_index <= frame_index_t'(cfg_count);
                rd_ready:   frame_index <= frame_index_t'(cfg_count + 1);
                default:    frame_index <= frame_index;
            endcase

            // Sticky until reset
            if (state == ready_idle) begin
                cfg_done <= 1'b1;
            end

            // Low only while waiting for power-up or a read request
            busy <= !(next_state == idle || next_state == ready_idle);
        end
    end

    // --------------------
    // Read result
    // --------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            rd_dval <= 1'b0;
            rd_data <= '0;
        end else begin
            rd_dval <= gap_end && rd_op;
            if (gap_end && rd_op) begin
                rd_data <= rsp.rd_value[31:16];
            end
        end
    end

    // No new frame while one is in flight or settling
    assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        req.start |-> !hold_off)
        else $error("start issued during frame or gap");

    // Samples only after configuration
    assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        rd_dval |-> cfg_done)
        else $error("rd_dval before configuration finished");

endmodule

/* source/adc_pkg.sv */
/* ADC SPI control subsystem shared types
   Frame, command and sample widths, bus bundles and controller state encoding */
package adc_pkg;

    // One full SPI frame on the wire
    typedef logic [31:0] spi_word_t;
    // Bit 15 read flag, bits 14:8 register address, bits 7:0 data
    typedef logic [15:0] adc_cmd_t;
    // Conversion result as returned by the converter
    typedef logic [15:0] adc_sample_t;
    // Frame counter, 0 before power-up, cfg_count+1 for the read command
    typedef logic [4:0]  frame_index_t;

    typedef enum logic [2:0] {
        idle,
        cfg_ready,
        cfg_wait,
        ready_idle,
        rd_ready,
        rd_wait,
        gap_wait
    } ctrl_state_t;

    // Controller to SPI master
    typedef struct packed {
        logic      start;
        spi_word_t word;
    } spi_req_t;

    // SPI master to controller
    typedef struct packed {
        logic      done;
        spi_word_t rd_value;
    } spi_rsp_t;

    // Pads toward the converter
    typedef struct packed {
        logic sclk;
        logic cs_n;
        logic mosi;
    } spi_pins_t;

endpackage

/* source/adc_spi_top.sv */
/* ADC SPI control subsystem top level
   Sequencer, configuration table and SPI master */
`timescale 1ns/1ps

module adc_spi_top import adc_pkg::*; #(
    parameter int unsigned cfg_count  = 16,
    parameter int unsigned gap_cycles = 255,
    parameter int unsigned sclk_half  = 2
) (
    input  logic        clk_sys,
    input  logic        rst_sys_n,
    input  logic        pw_on_en,
    input  logic        rd_en,
    input  logic        miso,
    output spi_pins_t   spi,
    output logic        busy,
    output logic        cfg_done,
    output logic        rd_dval,
    output adc_sample_t rd_data
);

    frame_index_t frame_index;
    adc_cmd_t     cmd;
    spi_req_t     spi_req;
    spi_rsp_t     spi_rsp;

    // Sequencer
    adc_ctrl #(
        .cfg_count  (cfg_count),
        .gap_cycles (gap_cycles)
    ) u_ctrl (
        .clk_sys     (clk_sys),
        .rst_sys_n   (rst_sys_n),
        .pw_on_en    (pw_on_en),
        .rd_en       (rd_en),
        .cmd         (cmd),
        .rsp         (spi_rsp),
        .frame_index (frame_index),
        .req         (spi_req),
        .busy        (busy),
        .cfg_done    (cfg_done),
        .rd_dval     (rd_dval),
        .rd_data     (rd_data)
    );

    // Command lookup by frame index
    adc_cfg_rom #(
        .cfg_count (cfg_count)
    ) u_cfg_rom (
        .clk_sys     (clk_sys),
        .rst_sys_n   (rst_sys_n),
        .frame_index (frame_index),
        .cmd         (cmd)
    );

    spi_master #(
        .sclk_half (sclk_half)
    ) u_spi (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .req       (spi_req),
        .miso      (miso),
        .rsp       (spi_rsp),
        .spi       (spi)
    );

endmodule

/* source/spi_master.sv */
/* SPI master, mode 0, MSB first
   Shifts one 32-bit frame per start pulse and returns the word captured on MISO */
`timescale 1ns/1ps

module spi_master import adc_pkg::*; #(
    parameter int unsigned sclk_half = 2
) (
    input  logic      clk_sys,
    input  logic      rst_sys_n,
    input  spi_req_t  req,
    input  logic      miso,
    output spi_rsp_t  rsp,
    output spi_pins_t spi
);

    localparam int div_w     = (sclk_half > 1) ? $clog2(sclk_half) : 1;
    // cs_n low time, 32 SCLK periods
    localparam int frame_len = 64 * sclk_half;

    logic             active;
    logic [div_w-1:0] div_cnt;
    logic [4:0]       bit_cnt;
    logic             half_tick;
    logic             sclk_q;
    logic             cs_n_q;
    logic             mosi_q;
    logic             frame_end;
    logic             done_q;
    spi_word_t        tx_sr;
    spi_word_t        rx_sr;

    // End of an SCLK half period
    assign half_tick = active && (div_cnt == div_w'(sclk_half - 1));

    // --------------------
    // Frame sequencing
    // --------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            active    <= 1'b0;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            sclk_q    <= 1'b0;
            cs_n_q    <= 1'b1;
            mosi_q    <= 1'b0;
            frame_end <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            frame_end <= 1'b0;
            // Done one cycle after cs_n rises
            done_q    <= frame_end;
            if (req.start && !active) begin
                // First bit out with cs_n falling
                active  <= 1'b1;
                cs_n_q  <= 1'b0;
                sclk_q  <= 1'b0;
                mosi_q  <= req.word[31];
                div_cnt <= '0;
                bit_cnt <= '0;
            end else if (half_tick) begin
                div_cnt <= '0;
                if (!sclk_q) begin
                    sclk_q <= 1'b1;
                end else begin
                    sclk_q <= 1'b0;
                    if (bit_cnt == 5'd31) begin
                        // Last fall coincides with cs_n release
                        active    <= 1'b0;
                        cs_n_q    <= 1'b1;
                        mosi_q    <= 1'b0;
                        frame_end <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        mosi_q  <= tx_sr[30];
                    end
                end
            end else if (active) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // --------------------
    // Shift registers
    // --------------------
    always_ff @(posedge clk_sys) begin
        if (req.start && !active) begin
            tx_sr <= req.word;
        end else if (half_tick && sclk_q) begin
            tx_sr <= {tx_sr[30:0], 1'b0};
        end
        // Sample on rising SCLK, held after the frame until the next one
        if (half_tick && !sclk_q) begin
            rx_sr <= {rx_sr[30:0], miso};
        end
    end

    assign rsp = '{done: done_q, rd_value: rx_sr};
    assign spi = '{sclk: sclk_q, cs_n: cs_n_q, mosi: mosi_q};

    // Chip select window is exactly one frame
    assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        req.start |=> (!spi.cs_n) [*frame_len] ##1 spi.cs_n)
        else $error("cs_n low window differs from %0d cycles", frame_len);

endmodule

/* verification/adc_spi_model.sv */
/* SPI slave model of the ADC
   Records each MOSI frame and returns a sample on MISO for read commands */
`timescale 1ns/1ps

module adc_spi_model import adc_pkg::*; (
    input  spi_pins_t   spi,
    input  adc_sample_t sample,
    output logic        miso,
    output spi_word_t   last_frame,
    output int          frame_count,
    output int          reads_seen
);

    spi_word_t   rx_word;
    adc_sample_t tx_shift;

    // --------------------
    // MOSI capture
    // --------------------
    initial begin
        rx_word     = '0;
        last_frame  = '0;
        frame_count = 0;
        forever begin
            @(negedge spi.cs_n);
            // Mode 0, converter samples on rising SCLK
            repeat (32) begin
                @(posedge spi.sclk);
                rx_word = {rx_word[30:0], spi.mosi};
            end
            @(posedge spi.cs_n);
            last_frame  = rx_word;
            frame_count = frame_count + 1;
        end
    end

    // --------------------
    // MISO drive
    // --------------------
    initial begin
        miso       <= 1'b0;
        tx_shift   = '0;
        reads_seen = 0;
        forever begin
            @(negedge spi.cs_n);
            // First MOSI bit settles with cs_n and carries the read flag
            #1;
            if (spi.mosi) begin
                tx_shift   = sample;
                reads_seen = reads_seen + 1;
            end else begin
                tx_shift = '0;
            end
            miso <= tx_shift[15];
            // Next bit after each falling SCLK, zeros once the sample is out
            repeat (32) begin
                @(negedge spi.sclk);
                tx_shift = {tx_shift[14:0], 1'b0};
                miso <= tx_shift[15];
            end
        end
    end

endmodule

/* verification/adc_spi_tb.sv */
/* Testbench for the ADC SPI control subsystem
   Power-up writes, settling gaps and reads under back-pressure against the stimulus file */
`timescale 1ns/1ps

module adc_spi_tb import adc_pkg::*; ();

    localparam int cfg_count       = 16;
    localparam int gap_cycles      = 255;
    localparam int sclk_half       = 2;
    localparam int n_reads         = 8;
    // Start to done of one frame
    localparam int frame_cycles    = 64 * sclk_half + 2;
    localparam int stim_len        = cfg_count + 1 + n_reads;
    // Every frame with its gap plus the idle phases, doubled
    localparam int watchdog_cycles =
        2 * ((cfg_count + n_reads) * (frame_cycles + gap_cycles) + 200);

    logic        clk_sys;
    logic        rst_sys_n;
    logic        pw_on_en;
    logic        rd_en;
    logic        miso;
    spi_pins_t   spi;
    logic        busy;
    logic        cfg_done;
    logic        rd_dval;
    adc_sample_t rd_data;

    adc_sample_t model_sample;
    spi_word_t   last_frame;
    int          frame_count;
    int          reads_seen;

    // Write commands, read command, then samples
    logic [15:0] stim_mem [0:stim_len-1];
    logic [31:0] rng;
    spi_word_t   exp_frame;
    int          frames_checked;
    int          dval_count;
    int          accepted;
    int          dropped;
    int          high_cnt;
    logic        cs_prev;
    logic        cfg_seen;

    adc_spi_top #(
        .cfg_count  (cfg_count),
        .gap_cycles (gap_cycles),
        .sclk_half  (sclk_half)
    ) uut (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .pw_on_en  (pw_on_en),
        .rd_en     (rd_en),
        .miso      (miso),
        .spi       (spi),
        .busy      (busy),
        .cfg_done  (cfg_done),
        .rd_dval   (rd_dval),
        .rd_data   (rd_data)
    );

    // Converter side, next sample follows the model's read count
    assign model_sample = stim_mem[cfg_count + 1 + reads_seen];

    adc_spi_model u_model (
        .spi         (spi),
        .sample      (model_sample),
        .miso        (miso),
        .last_frame  (last_frame),
        .frame_count (frame_count),
        .reads_seen  (reads_seen)
    );

    always #10 clk_sys = ~clk_sys;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        next_random = state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s actual 0x%h expected 0x%h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value check failed");
        end
    endtask

    // --------------------
    // Monitors
    // --------------------
    always @(negedge clk_sys) begin
        if (rst_sys_n) begin
            // Frame finished since the last look
            if (frame_count != frames_checked) begin
                if (frames_checked < cfg_count) begin
                    exp_frame = {stim_mem[frames_checked], 16'h0000};
                end else begin
                    exp_frame = {stim_mem[cfg_count], 16'h0000};
                end
                check_value("mosi frame", last_frame, exp_frame);
                frames_checked = frames_checked + 1;
            end
            // Settling gap, none after the last configuration write
            if (spi.cs_n) begin
                high_cnt = high_cnt + 1;
            end else begin
                if (cs_prev && frames_checked > 0 && frames_checked != cfg_count) begin
                    check_value("cs_n high cycles",
                                32'((high_cnt < gap_cycles) ? high_cnt : gap_cycles),
                                32'(gap_cycles));
                end
                high_cnt = 0;
            end
            cs_prev = spi.cs_n;
            // Sample published at the end of a read gap
            if (rd_dval) begin
                check_value("rd_dval within accepted reads", 32'(dval_count < accepted), 32'd1);
                check_value("rd_data", 32'(rd_data),
                            32'(stim_mem[cfg_count + 1 + dval_count]));
                dval_count = dval_count + 1;
            end
            // Sticky until reset
            if (cfg_seen) begin
                check_value("cfg_done", 32'(cfg_done), 32'd1);
            end
            cfg_seen = cfg_seen | cfg_done;
        end
    end

    // Run limit
    initial begin
        repeat (watchdog_cycles) @(posedge clk_sys);
        $display("Timeout: the DUT did not finish within %0d clock cycles", watchdog_cycles);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        clk_sys        = 1'b0;
        rst_sys_n      = 1'b0;
        pw_on_en       = 1'b0;
        rd_en          = 1'b0;
        rng            = 32'h6aca;
        frames_checked = 0;
        dval_count     = 0;
        accepted       = 0;
        dropped        = 0;
        high_cnt       = 0;
        cs_prev        = 1'b1;
        cfg_seen       = 1'b0;
        $readmemh("verification/adc_stimulus.txt", stim_mem);
        repeat (3) @(posedge clk_sys);
        rst_sys_n <= 1'b1;

        // Quiet until power-on
        repeat (50) begin
            @(negedge clk_sys);
            check_value("spi.cs_n", 32'(spi.cs_n), 32'd1);
            check_value("spi.sclk", 32'(spi.sclk), 32'd0);
            check_value("busy", 32'(busy), 32'd0);
            check_value("cfg_done", 32'(cfg_done), 32'd0);
        end

        // Configuration writes, busy through the last frame
        @(posedge clk_sys);
        pw_on_en <= 1'b1;
        @(posedge clk_sys);
        while (frame_count < cfg_count) begin
            @(negedge clk_sys);
            if (frame_count < cfg_count) begin
                check_value("busy", 32'(busy), 32'd1);
            end
        end

        // Idle after configuration, no frame without a request
        while (!cfg_done) @(negedge clk_sys);
        repeat (50) begin
            @(negedge clk_sys);
            check_value("busy", 32'(busy), 32'd0);
        end
        check_value("frames after configuration", 32'(frame_count), 32'(cfg_count));

        // Read pulses at random spacing, busy at request time decides acceptance
        while (accepted < n_reads) begin
            rng = next_random(rng);
            repeat (rng[19:16]) @(posedge clk_sys);
            @(posedge clk_sys);
            rd_en <= 1'b1;
            @(negedge clk_sys);
            if (busy) begin
                dropped = dropped + 1;
            end else begin
                accepted = accepted + 1;
            end
            @(posedge clk_sys);
            rd_en <= 1'b0;
        end
        while (dval_count < n_reads) @(negedge clk_sys);
        repeat (20) @(negedge clk_sys);

        check_value("read frame count", 32'(frame_count - cfg_count), 32'(accepted));
        check_value("rd_dval count", 32'(dval_count), 32'(accepted));
        check_value("model read count", 32'(reads_seen), 32'(accepted));
        check_value("requests dropped while busy", 32'(dropped > 0), 32'd1);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* verification/adc_stimulus.txt */
// Words 0-15: expected register write commands {rw, addr[6:0], data[7:0]}, table order
// Word 16: expected read command, words 17-24: sample returned for each accepted read
0080 0100 021f 0304
0400 0522 0603 0710
0800 0900 0a40 0b0c
0c01 0d00 0e08 0f01
9000
a5c3 1234 fedc 0001
7f80 8000 3c5a ffff
